/* list.f */
logic/rename_pkg.sv
logic/branch_buffer.sv
logic/rat_table.sv
logic/free_list.sv
logic/rename_top.sv
sim/rename_assertions.sv
sim/rename_tb.sv

/* sim/rename_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rename_tb import rename_pkg::*; ();

    localparam int          NUM_CYCLES = 500;                    // Random stimulus length
    localparam int          MAX_CYCLES = 4 * NUM_CYCLES;         // Hang limit
    localparam logic [31:0] LFSR_TAPS  = 32'h80200003;
    localparam opcode_t     OP_STORE   = 7'b0100011;             // No rd, no checkpoint
    localparam opcode_t     OP_TABLE [8] = '{OP_BRANCH, OP_JAL, OP_JALR, 7'b0110011,
                                            7'b0010011, 7'b0000011, 7'b0010111, OP_STORE};

    logic clk = 1'b0;
    logic rst;
    logic instr_valid, resolve_valid, mispredict, free_valid;
    opcode_t   opcode;
    arch_reg_t rd, rs1, rs2;
    pc_t       pc, resolve_pc;
    phys_tag_t free_tag;
    logic      out_valid, pd_valid, bb_full;
    phys_tag_t ps1, ps2, pd, old_pd;

    logic [31:0] lfsr = 32'h8510c4f7;
    pc_t         pc_next;                                        // Sequential fetch address
    int          cycle_cnt = 0;

    // Reference state
    phys_tag_t m_map [NUM_ARCH];                                 // Live map
    phys_tag_t m_snap [NUM_CKPT][NUM_ARCH];                      // Map per checkpoint
    int        m_ptr [NUM_CKPT];                                 // Read count per checkpoint
    pc_t       m_pc [NUM_CKPT];                                  // Branch PC per checkpoint
    int        m_head, m_count;
    phys_tag_t m_q [FREE_DEPTH];                                 // Free tag queue
    int        m_rd, m_wr;                                       // Absolute pop and push counts
    phys_tag_t pend [$];                                         // Old tags waiting to be freed

    // Expected DUT outputs after the last edge
    logic      e_out_valid, e_pd_valid, e_bb_full;
    phys_tag_t e_ps1, e_ps2, e_pd, e_old_pd;

    always #20 clk = ~clk;

    rename_top rename_top_i (.*);

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};                              // One step per bit
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic void reset_model();
        for (int i = 0; i < NUM_ARCH; i++)
            m_map[i] = phys_tag_t'(i);                           // Identity map
        for (int i = 0; i < FREE_DEPTH; i++)
            m_q[i] = phys_tag_t'(NUM_ARCH + i);
        m_rd = 0;
        m_wr = FREE_DEPTH;
        m_head = 0;
        m_count = 0;
        e_out_valid = 1'b0;
        e_pd_valid = 1'b0;
        e_bb_full = 1'b0;
    endfunction

    // One clock edge of the renaming rules, applied to the inputs now on the pins
    function automatic void step_model();
        logic hit, restore, pop, br, accept, wr;
        int   slot;
        hit     = resolve_valid && (m_count > 0) && (m_pc[m_head] == resolve_pc);
        restore = hit && mispredict;
        pop     = hit && !mispredict;
        br      = opcode inside {OP_JAL, OP_JALR, OP_BRANCH};
        accept  = instr_valid && !restore && !(br && (m_count == NUM_CKPT));
        wr      = accept && (rd != '0) && (opcode inside {OP_WRITES_RD});
        e_out_valid = accept;
        e_pd_valid  = wr;
        if (accept) begin
            e_ps1 = m_map[rs1];                                  // Sources before own write
            e_ps2 = m_map[rs2];
        end
        if (wr) begin
            e_pd     = m_q[m_rd % FREE_DEPTH];
            e_old_pd = m_map[rd];
            pend.push_back(e_old_pd);
        end
        if (free_valid) begin
            m_q[m_wr % FREE_DEPTH] = free_tag;
            m_wr++;
        end
        if (restore) begin
            for (int i = 0; i < NUM_ARCH; i++)
                m_map[i] = m_snap[m_head][i];
            m_rd = m_ptr[m_head];                                // Reissue squashed tags
            m_count = 0;
        end else begin
            if (wr) begin
                m_map[rd] = e_pd;
                m_rd++;
            end
            if (pop) begin
                m_head = (m_head + 1) % NUM_CKPT;
                m_count--;
            end
            if (accept && br) begin
                slot = (m_head + m_count) % NUM_CKPT;            // Youngest position
                m_pc[slot] = pc;
                m_ptr[slot] = m_rd;
                for (int i = 0; i < NUM_ARCH; i++)
                    m_snap[slot][i] = m_map[i];                  // After own rd write
                m_count++;
            end
        end
        e_bb_full = (m_count == NUM_CKPT);
    endfunction

    task automatic drive_next();
        logic [2:0] k;
        int         oldest;
        k = 3'(rand_bits(3));
        oldest = (m_count > 0) ? m_ptr[m_head] : m_rd;           // Lowest pointer a restore can reach
        pc_next = pc_next + 32'd4;
        instr_valid <= (rand_bits(2) != 0);
        opcode      <= (m_wr - m_rd < 1) ? OP_STORE : OP_TABLE[k];   // Hold off when no tag left
        rd          <= arch_reg_t'(rand_bits(5));
        rs1         <= arch_reg_t'(rand_bits(5));
        rs2         <= arch_reg_t'(rand_bits(5));
        pc          <= pc_next;
        resolve_valid <= (rand_bits(2) == 0);
        if (m_count == 0 || rand_bits(3) == 0)
            resolve_pc <= pc_t'({rand_bits(30), 2'b10});         // Never a fetched PC
        else
            resolve_pc <= m_pc[m_head];
        mispredict <= (rand_bits(2) == 0);
        if (pend.size() > 0 && rand_bits(1) && (m_wr - oldest < FREE_DEPTH)) begin
            free_valid <= 1'b1;
            free_tag   <= pend.pop_front();
        end else begin
            free_valid <= 1'b0;
        end
    endtask

    task automatic check_tag(input string name, input phys_tag_t got, input phys_tag_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Outputs settle between edges
    always @(negedge clk) begin
        if (!rst) begin
            if (rename_top_i.branch_buffer_i.rename_assertions_i.fail_cnt != 0) begin
                $display("Branch buffer assertion failed at %0t ns", $time);
                $display("Test failed");
                $fatal(1, "Stopped at assertion failure");
            end
            check_bit("out_valid", out_valid, e_out_valid);
            check_bit("pd_valid", pd_valid, e_pd_valid);
            check_bit("bb_full", bb_full, e_bb_full);
            if (e_out_valid) begin
                check_tag("ps1", ps1, e_ps1);
                check_tag("ps2", ps2, e_ps2);
            end
            if (e_pd_valid) begin
                check_tag("pd", pd, e_pd);
                check_tag("old_pd", old_pd, e_old_pd);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $fatal(1, "Cycle limit reached");
        end
    end

    initial begin
        rst = 1'b1;
        instr_valid = 1'b0;
        opcode = OP_STORE;
        rd = '0;
        rs1 = '0;
        rs2 = '0;
        pc = '0;
        resolve_valid = 1'b0;
        resolve_pc = '0;
        mispredict = 1'b0;
        free_valid = 1'b0;
        free_tag = '0;
        pc_next = 32'h0000_1000;
        reset_model();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        drive_next();                                            // Inputs for first live edge
        repeat (NUM_CYCLES) begin
            @(posedge clk);
            step_model();
            drive_next();
        end
        @(posedge clk);                                          // Last compare done
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/rename_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module rename_assertions import rename_pkg::*; (
    input wire            clk,
    input wire            rst,
    input wire            ckpt_copy,
    input wire ckpt_idx_t copy_slot,
    input wire            ckpt_restore,
    input wire ckpt_idx_t restore_slot,
    input wire            bb_full,
    input wire bb_state_t state
);

    int fail_cnt = 0;                          // Failed assertions so far

    // Save and roll back never collide on one slot
    property no_copy_restore_same_slot;
        @(posedge clk) disable iff (rst)
            !(ckpt_copy && ckpt_restore && (copy_slot == restore_slot));
    endproperty

    // Full buffer takes no new checkpoint
    property no_copy_when_full;
        @(posedge clk) disable iff (rst)
            bb_full |-> !ckpt_copy;
    endproperty

    // Misprediction empties the ring
    property restore_empties;
        @(posedge clk) disable iff (rst)
            ckpt_restore |=> (state == IDLE) && !bb_full;
    endproperty

    a_slot: assert property (no_copy_restore_same_slot)
        else begin
            fail_cnt++;
            $error("copy and restore on one slot");
        end

    a_full: assert property (no_copy_when_full)
        else begin
            fail_cnt++;
            $error("checkpoint taken while full");
        end

    a_restore: assert property (restore_empties)
        else begin
            fail_cnt++;
            $error("buffer not empty after restore");
        end

endmodule

bind branch_buffer rename_assertions rename_assertions_i (
    .clk          (clk),
    .rst          (rst),
    .ckpt_copy    (ckpt_copy),
    .copy_slot    (copy_slot),
    .ckpt_restore (ckpt_restore),
    .restore_slot (restore_slot),
    .bb_full      (bb_full),
    .state        (state)
);

`default_nettype wire

/* logic/rename_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rename_top import rename_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    // Decode
    input  wire            instr_valid,
    input  wire opcode_t   opcode,
    input  wire arch_reg_t rd,
    input  wire arch_reg_t rs1,
    input  wire arch_reg_t rs2,
    input  wire pc_t       pc,
    // Branch resolution
    input  wire            resolve_valid,
    input  wire pc_t       resolve_pc,
    input  wire            mispredict,
    // Commit
    input  wire            free_valid,
    input  wire phys_tag_t free_tag,
    // Rename result
    output logic           out_valid,
    output phys_tag_t      ps1,
    output phys_tag_t      ps2,
    output phys_tag_t      pd,
    output logic           pd_valid,
    output phys_tag_t      old_pd,
    output logic           bb_full
);

    logic      instr_accept;                   // From branch buffer
    logic      ckpt_copy;
    ckpt_idx_t copy_slot;
    logic      ckpt_restore;
    ckpt_idx_t restore_slot;
    phys_tag_t alloc_tag;                      // Free list to RAT
    logic      alloc_req;                      // RAT to free list

    // Checkpoint control
    branch_buffer branch_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .opcode       (opcode),
        .pc           (pc),
        .resolve_valid(resolve_valid),
        .resolve_pc   (resolve_pc),
        .mispredict   (mispredict),
        .instr_accept (instr_accept),
        .ckpt_copy    (ckpt_copy),
        .copy_slot    (copy_slot),
        .ckpt_restore (ckpt_restore),
        .restore_slot (restore_slot),
        .bb_full      (bb_full)
    );

    // Alias table
    rat_table rat_table_i (
        .clk          (clk),
        .rst          (rst),
        .instr_accept (instr_accept),
        .rd           (rd),
        .rs1          (rs1),
        .rs2          (rs2),
        .opcode       (opcode),
        .alloc_tag    (alloc_tag),
        .ckpt_copy    (ckpt_copy),
        .copy_slot    (copy_slot),
        .ckpt_restore (ckpt_restore),
        .restore_slot (restore_slot),
        .alloc_req    (alloc_req),
        .out_valid    (out_valid),
        .ps1          (ps1),
        .ps2          (ps2),
        .pd           (pd),
        .old_pd       (old_pd),
        .pd_valid     (pd_valid)
    );

    // Free tag queue
    free_list free_list_i (
        .clk          (clk),
        .rst          (rst),
        .alloc_req    (alloc_req),
        .free_valid   (free_valid),
        .free_tag     (free_tag),
        .ckpt_copy    (ckpt_copy),
        .copy_slot    (copy_slot),
        .ckpt_restore (ckpt_restore),
        .restore_slot (restore_slot),
        .alloc_tag    (alloc_tag)
    );

endmodule

`default_nettype wire

/* logic/free_list.sv */
`timescale 1ns/100ps
`default_nettype none

module free_list import rename_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            alloc_req,          // Pop one tag
    input  wire            free_valid,         // Push from commit
    input  wire phys_tag_t free_tag,
    input  wire            ckpt_copy,
    input  wire ckpt_idx_t copy_slot,
    input  wire            ckpt_restore,
    input  wire ckpt_idx_t restore_slot,
    output phys_tag_t      alloc_tag           // Tag at read pointer
);

    // Extra bit above the index for wrap tracking
    typedef logic [$clog2(FREE_DEPTH):0] fl_ptr_t;

    phys_tag_t tag_q [FREE_DEPTH];             // Circular tag queue
    fl_ptr_t   rd_ptr;
    fl_ptr_t   wr_ptr;
    fl_ptr_t   rd_ptr_nxt;                     // After this cycle's pop
    fl_ptr_t   ckpt_ptr [NUM_CKPT];            // Saved read pointers

    assign alloc_tag  = tag_q[rd_ptr[$clog2(FREE_DEPTH)-1:0]];
    assign rd_ptr_nxt = alloc_req ? rd_ptr + 1'b1 : rd_ptr;

    // Queue and pointers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= fl_ptr_t'(FREE_DEPTH);   // Queue starts full
            for (int i = 0; i < FREE_DEPTH; i++)
                tag_q[i] <= phys_tag_t'(NUM_ARCH + i);   // Tags 32..63
        end else begin
            if (ckpt_restore)
                rd_ptr <= ckpt_ptr[restore_slot];   // Reissue squashed tags
            else
                rd_ptr <= rd_ptr_nxt;
            // Write side never rolls back, commits are kept
            if (free_valid) begin
                tag_q[wr_ptr[$clog2(FREE_DEPTH)-1:0]] <= free_tag;
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // Read pointer snapshot with the branch's own pop applied
    always_ff @(posedge clk) begin
        if (ckpt_copy)
            ckpt_ptr[copy_slot] <= rd_ptr_nxt;
    end

endmodule

`default_nettype wire

/* logic/rat_table.sv */
`timescale 1ns/100ps
`default_nettype none

module rat_table import rename_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            instr_accept,       // Instruction is renamed
    input  wire arch_reg_t rd,
    input  wire arch_reg_t rs1,
    input  wire arch_reg_t rs2,
    input  wire opcode_t   opcode,
    input  wire phys_tag_t alloc_tag,          // Head of free list
    input  wire            ckpt_copy,
    input  wire ckpt_idx_t copy_slot,
    input  wire            ckpt_restore,
    input  wire ckpt_idx_t restore_slot,
    output logic           alloc_req,          // Pop free list
    output logic           out_valid,
    output phys_tag_t      ps1,
    output phys_tag_t      ps2,
    output phys_tag_t      pd,
    output phys_tag_t      old_pd,             // Previous mapping of rd
    output logic           pd_valid
);

    phys_tag_t live_map [NUM_ARCH];            // Current speculative map
    phys_tag_t snap_map [NUM_CKPT][NUM_ARCH];  // One map per checkpoint
    phys_tag_t next_map [NUM_ARCH];            // Live map with this update

    logic writes_rd;                           // Opcode writes a nonzero rd

    // x0 never gets a new tag, so its entry stays 0
    assign writes_rd = (opcode inside {OP_WRITES_RD}) && (rd != '0);
    assign alloc_req = instr_accept && writes_rd;

    // Map after this instruction
    always_comb begin
        next_map = live_map;
        if (alloc_req)
            next_map[rd] = alloc_tag;
    end

    // Live map, identity after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH; i++)
                live_map[i] <= phys_tag_t'(i);
        end else if (ckpt_restore) begin
            live_map <= snap_map[restore_slot];   // Roll back whole map
        end else begin
            live_map <= next_map;
        end
    end

    // Snapshot includes the branch's own rd write
    always_ff @(posedge clk) begin
        if (ckpt_copy)
            snap_map[copy_slot] <= next_map;
    end

    // Output strobes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            pd_valid  <= 1'b0;
        end else begin
            out_valid <= instr_accept;
            pd_valid  <= alloc_req;
        end
    end

    // Renamed operands, sources see the map before this rd write
    always_ff @(posedge clk) begin
        if (instr_accept) begin
            ps1 <= live_map[rs1];
            ps2 <= live_map[rs2];
            if (alloc_req) begin
                pd     <= alloc_tag;
                old_pd <= live_map[rd];        // Freed at commit
            end else begin
                pd     <= '0;
                old_pd <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/branch_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module branch_buffer import rename_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire          instr_valid,          // Decoded instruction present
    input  wire opcode_t opcode,
    input  wire pc_t     pc,                   // PC of decoded instruction
    input  wire          resolve_valid,        // Resolution strobe
    input  wire pc_t     resolve_pc,           // PC of resolved branch
    input  wire          mispredict,           // Resolution was wrong
    output logic         instr_accept,         // Qualified instr_valid
    output logic         ckpt_copy,            // Save RAT and free list
    output ckpt_idx_t    copy_slot,
    output logic         ckpt_restore,         // Roll back RAT and free list
    output ckpt_idx_t    restore_slot,
    output logic         bb_full               // Registered full flag
);

    pc_t       pc_ring [NUM_CKPT];             // Branch PC per slot
    ckpt_idx_t head;                           // Oldest live checkpoint
    ckpt_idx_t tail;                           // Next free slot
    bb_state_t state;
    bb_state_t state_nxt;

    logic is_branch;                           // Jump or conditional branch
    logic head_match;                          // Resolution hits oldest entry
    logic do_push;
    logic do_pop;
    logic do_restore;

    // Opcode classification
    assign is_branch = opcode inside {OP_JAL, OP_JALR, OP_BRANCH};

    // In-order resolution, only the head entry is compared
    assign head_match = resolve_valid && (state != IDLE) &&
                        (pc_ring[head] == resolve_pc);
    assign do_restore = head_match && mispredict;    // Squash all checkpoints
    assign do_pop     = head_match && !mispredict;   // Retire oldest

    // Drop the instruction on a squash, or a branch with no slot left
    assign instr_accept = instr_valid && !do_restore && !(is_branch && bb_full);
    assign do_push      = instr_accept && is_branch;

    // Checkpoint controls for RAT and free list, same cycle
    assign ckpt_copy    = do_push;
    assign copy_slot    = tail;
    assign ckpt_restore = do_restore;
    assign restore_slot = head;

    // Occupancy FSM
    always_comb begin
        state_nxt = state;
        if (do_restore) begin
            state_nxt = IDLE;                  // Buffer emptied
        end else if (do_push && !do_pop) begin
            if (ckpt_idx_t'(tail + 1'b1) == head)
                state_nxt = FULL;              // Eighth slot taken
            else
                state_nxt = TRACKING;
        end else if (do_pop && !do_push) begin
            if (ckpt_idx_t'(head + 1'b1) == tail)
                state_nxt = IDLE;              // Last one retired
            else
                state_nxt = TRACKING;
        end
        // Push with pop keeps the count
    end

    // Pointers, state and full flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            head    <= '0;
            tail    <= '0;
            bb_full <= 1'b0;
        end else begin
            state   <= state_nxt;
            bb_full <= (state_nxt == FULL);    // Registered full level
            if (do_restore) begin
                head <= '0;                    // Restart ring at slot 0
                tail <= '0;
            end else begin
                if (do_push)
                    tail <= tail + 1'b1;
                if (do_pop)
                    head <= head + 1'b1;
            end
        end
    end

    // PC ring write at the tail
    always_ff @(posedge clk) begin
        if (do_push)
            pc_ring[tail] <= pc;
    end

endmodule

`default_nettype wire

/* logic/rename_pkg.sv */
`default_nettype none

package rename_pkg;

    // Core sizes
    localparam int NUM_ARCH   = 32;            // Architectural registers x0..x31
    localparam int NUM_PHYS   = 64;            // Physical register file entries
    localparam int NUM_CKPT   = 8;             // Live branch checkpoints
    localparam int FREE_DEPTH = 32;            // Free tags after reset

    typedef logic [$clog2(NUM_ARCH)-1:0] arch_reg_t;   // rd, rs1, rs2 numbers
    typedef logic [$clog2(NUM_PHYS)-1:0] phys_tag_t;   // Physical tag
    typedef logic [$clog2(NUM_CKPT)-1:0] ckpt_idx_t;   // Checkpoint slot
    typedef logic [31:0]                 pc_t;         // Instruction address
    typedef logic [6:0]                  opcode_t;     // Major opcode, instr[6:0]

    // Opcodes that take a checkpoint
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    // Opcodes with an rd write
    localparam opcode_t OP_WRITES_RD [7] = '{
        7'b0110011,                            // OP
        7'b0010011,                            // OP-IMM
        7'b0000011,                            // LOAD
        7'b0110111,                            // LUI
        7'b0010111,                            // AUIPC
        OP_JAL,                                // Link register
        OP_JALR                                // Link register
    };

    // Branch buffer occupancy
    typedef enum logic [1:0] {
        IDLE,                                  // No checkpoint live
        TRACKING,                              // One to seven live
        FULL                                   // All eight slots taken
    } bb_state_t;

endpackage

`default_nettype wire
